// ==== mem_stage.f ====
+incdir+.
mem_stage_pkg.sv
store_formatter.sv
mem_access_ctrl.sv
load_aligner.sv
data_ram.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the memory stage testbench with Verilator.
# The exit status is nonzero when the testbench reports a failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_stage -f mem_stage.f

./obj_dir/Vtb_mem_stage

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_macros.svh"

module tb_mem_stage;
    import mem_stage_pkg::*;

    logic       clk;
    logic       rst;
    mem_req_t   req;
    mem_rsp_t   rsp;
    mem_rsp_t   exp_next;           // response owed by the request now on req
    mem_rsp_t   exp_q;              // one-deep queue, lines up with rsp
    logic [7:0] shadow [0:1023];    // byte image of the low 256 words
    logic       link;               // shadow of the ll/sc link bit
    int         seed;

    mem_stage_top i_mem_stage_top (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always_ff @(posedge clk) begin
        exp_q <= exp_next;
    end

    task automatic fail_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "response mismatch on %s", name);
    endtask

    a_rsp_valid: assert property (@(posedge clk) disable iff (rst) rsp.valid == exp_q.valid)
        else fail_value("rsp.valid", 32'($sampled(exp_q.valid)), 32'($sampled(rsp.valid)));
    a_rsp_data: assert property (@(posedge clk) disable iff (rst) rsp.data == exp_q.data)
        else fail_value("rsp.data", $sampled(exp_q.data), $sampled(rsp.data));
    a_err_load: assert property (@(posedge clk) disable iff (rst)
        rsp.addr_error_load == exp_q.addr_error_load)
        else fail_value("rsp.addr_error_load", 32'($sampled(exp_q.addr_error_load)),
                        32'($sampled(rsp.addr_error_load)));
    a_err_store: assert property (@(posedge clk) disable iff (rst)
        rsp.addr_error_store == exp_q.addr_error_store)
        else fail_value("rsp.addr_error_store", 32'($sampled(exp_q.addr_error_store)),
                        32'($sampled(rsp.addr_error_store)));

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [5:0] op_at(input logic [3:0] n);
        case (n)
            4'd0:    return `OP_LW;
            4'd1:    return `OP_LH;
            4'd2:    return `OP_LHU;
            4'd3:    return `OP_LB;
            4'd4:    return `OP_LBU;
            4'd5:    return `OP_LWL;
            4'd6:    return `OP_LWR;
            4'd7:    return `OP_LL;
            4'd8:    return `OP_SW;
            4'd9:    return `OP_SH;
            4'd10:   return `OP_SB;
            4'd11:   return `OP_SWL;
            4'd12:   return `OP_SWR;
            4'd13:   return `OP_SC;
            default: return `OP_LW;
        endcase
    endfunction

    // reference model, updates shadow memory and link as the RAM will at the next edge
    task automatic predict(input mem_req_t r, output mem_rsp_t e);
        logic [5:0]  op;
        logic [31:0] word;
        logic [31:0] rt;
        logic [7:0]  b;
        logic [15:0] h;
        logic        store;
        logic        bad;
        int          kk;
        op = r.instr.itype.op;
        rt = r.rt_value;
        kk = int'(r.addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = shadow[{r.addr[9:2], 2'(i)}];
        end
        b     = word[8*kk +: 8];
        h     = r.addr[1] ? word[31:16] : word[15:0];
        store = op inside {`OP_SW, `OP_SH, `OP_SB, `OP_SWL, `OP_SWR, `OP_SC};
        case (op)
            `OP_LW, `OP_LL, `OP_SW, `OP_SC: bad = (kk != 0);
            `OP_LH, `OP_LHU, `OP_SH:        bad = r.addr[0];
            default:                        bad = 1'b0;
        endcase
        e                  = '0;
        e.valid            = 1'b1;
        e.addr_error_load  = bad && !store;
        e.addr_error_store = bad && store;
        if (!bad) begin
            case (op)
                `OP_LW:  e.data = word;
                `OP_LH:  e.data = {{16{h[15]}}, h};
                `OP_LHU: e.data = {16'h0000, h};
                `OP_LB:  e.data = {{24{b[7]}}, b};
                `OP_LBU: e.data = {24'h000000, b};
                `OP_LL: begin
                    e.data = word;
                    link   = 1'b1;
                end
                `OP_LWL: begin
                    e.data = rt;    // memory bytes 0..k land in the top of rt
                    for (int i = 0; i <= kk; i++) e.data[8*(3-kk+i) +: 8] = word[8*i +: 8];
                end
                `OP_LWR: begin
                    e.data = rt;    // memory bytes k..3 land in the bottom of rt
                    for (int i = kk; i < 4; i++) e.data[8*(i-kk) +: 8] = word[8*i +: 8];
                end
                `OP_SW: begin
                    for (int i = 0; i < 4; i++) shadow[{r.addr[9:2], 2'(i)}] = rt[8*i +: 8];
                end
                `OP_SH: begin
                    shadow[{r.addr[9:2], 2'(kk)}]     = rt[7:0];
                    shadow[{r.addr[9:2], 2'(kk + 1)}] = rt[15:8];
                end
                `OP_SB: shadow[r.addr[9:0]] = rt[7:0];
                `OP_SWL: begin
                    for (int i = 0; i <= kk; i++) begin
                        shadow[{r.addr[9:2], 2'(i)}] = rt[8*(3-kk+i) +: 8];
                    end
                end
                `OP_SWR: begin
                    for (int i = kk; i < 4; i++) begin
                        shadow[{r.addr[9:2], 2'(i)}] = rt[8*(i-kk) +: 8];
                    end
                end
                `OP_SC: begin
                    if (link) begin
                        for (int i = 0; i < 4; i++) shadow[{r.addr[9:2], 2'(i)}] = rt[8*i +: 8];
                        e.data = 32'd1;
                    end
                    link = 1'b0;
                end
                default: e.data = '0;
            endcase
        end
    endtask

    task automatic issue(input logic [5:0] op, input logic [31:0] addr, input logic [31:0] rt);
        mem_req_t r;
        mem_rsp_t e;
        r.valid          = 1'b1;
        r.instr.raw      = rand_word();   // rs, rt and imm fields are don't care
        r.instr.itype.op = op;
        r.addr           = addr;
        r.rt_value       = rt;
        @(posedge clk);
        #10;
        predict(r, e);
        req      = r;
        exp_next = e;
    endtask

    task automatic go_idle();
        @(posedge clk);
        #10;
        req      = '0;
        exp_next = '0;
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        int          n;
        int          w;
        int          off;
        seed     = 32'hf8fb9f4c;
        rst      = 1'b1;
        req      = '0;
        exp_next = '0;
        link     = 1'b0;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;

        // known contents for words 0..15, the only words read below
        for (w = 0; w < 16; w++) issue(`OP_SW, 32'(w) << 2, rand_word());

        issue(`OP_SW, 32'h20, 32'hcafe_0123);
        issue(`OP_LW, 32'h20, rand_word());     // back to back with the store
        go_idle();
        issue(`OP_LW, 32'h20, rand_word());

        // odd offsets get a negative byte, even ones a positive byte
        for (off = 0; off < 4; off++) begin
            r1 = rand_word();
            issue(`OP_SB, 32'h24 + off, {r1[31:8], off[0], r1[6:0]});
            issue(`OP_LB, 32'h24 + off, rand_word());
            issue(`OP_LBU, 32'h24 + off, rand_word());
        end
        for (off = 0; off < 4; off += 2) begin
            r1 = rand_word();
            issue(`OP_SH, 32'h28 + off, {r1[31:16], off[1], r1[14:0]});
            issue(`OP_LH, 32'h28 + off, rand_word());
            issue(`OP_LHU, 32'h28 + off, rand_word());
        end

        for (off = 0; off < 4; off++) begin
            issue(`OP_SWL, 32'h2c + off, rand_word());
            issue(`OP_LW, 32'h2c, rand_word());
            issue(`OP_SWR, 32'h30 + off, rand_word());
            issue(`OP_LW, 32'h30, rand_word());
            issue(`OP_LWL, 32'h34 + off, rand_word());
            issue(`OP_LWR, 32'h34 + off, rand_word());
        end

        issue(`OP_LW, 32'h39, rand_word());
        issue(`OP_LH, 32'h3b, rand_word());
        issue(`OP_LL, 32'h3a, rand_word());
        issue(`OP_SW, 32'h39, rand_word());
        issue(`OP_SH, 32'h3b, rand_word());
        issue(`OP_SC, 32'h3b, rand_word());
        issue(`OP_LW, 32'h38, rand_word());

        issue(`OP_LL, 32'h3c, rand_word());
        issue(`OP_SC, 32'h3c, rand_word());
        issue(`OP_LW, 32'h3c, rand_word());
        issue(`OP_SC, 32'h3c, rand_word());     // link already cleared
        issue(`OP_LW, 32'h3c, rand_word());
        issue(`OP_SC, 32'h00, rand_word());
        issue(`OP_LW, 32'h00, rand_word());

        // words 0..15 only, upper address bits random
        for (n = 0; n < 200; n++) begin
            r1 = rand_word();
            r2 = rand_word();
            issue(op_at(r2[9:6]), {r1[31:10], 4'b0000, r2[5:0]}, rand_word());
        end

        go_idle();
        for (n = 0; n < 10; n++) begin
            @(posedge clk);
            #1;
            if (rsp.valid === 1'b0) break;
        end
        if (rsp.valid !== 1'b0) begin
            $display("timeout: response valid stayed high after the last request");
            $display("CHECKS FAILED");
            $fatal(1, "drain timeout");
        end else begin
            repeat (2) @(posedge clk);
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== mem_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_macros.svh"

module mem_stage_top (
    input  logic                      clk,
    input  logic                      rst,
    input  mem_stage_pkg::mem_req_t   req,
    output mem_stage_pkg::mem_rsp_t   rsp
);
    import mem_stage_pkg::*;

    ram_wr_t                ram_wr;
    logic [`RAM_ADDR_W-1:0] rd_word_addr;
    m2_stage_t              m2;
    logic [`DATA_W-1:0]     rdata;

    // stage M
    mem_access_ctrl i_mem_access_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .ram_wr       (ram_wr),
        .rd_word_addr (rd_word_addr),
        .m2           (m2)
    );

    data_ram #(
        .depth_words (1 << `RAM_ADDR_W)
    ) i_data_ram (
        .clk          (clk),
        .wr           (ram_wr),
        .rd_word_addr (rd_word_addr),
        .rdata        (rdata)
    );

    // stage M2
    load_aligner i_load_aligner (
        .m2    (m2),
        .rdata (rdata),
        .rsp   (rsp)
    );

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_macros.svh"

module data_ram #(
    parameter int depth_words = 1 << `RAM_ADDR_W
) (
    input  logic                    clk,
    input  mem_stage_pkg::ram_wr_t  wr,
    input  logic [`RAM_ADDR_W-1:0]  rd_word_addr,
    output logic [`DATA_W-1:0]      rdata
);

    logic [`DATA_W-1:0] mem [depth_words];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr.be[i]) begin
                mem[wr.word_addr][8*i +: 8] <= wr.data[8*i +: 8];
            end
        end
        rdata <= mem[rd_word_addr];   // old word on a same-cycle write
    end

    // once driven, the enables stay known
    a_be_known: assert property (@(posedge clk)
        !$isunknown($past(wr.be)) |-> !$isunknown(wr.be));

endmodule

`default_nettype wire

// ==== load_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_macros.svh"

module load_aligner (
    input  mem_stage_pkg::m2_stage_t m2,
    input  logic [`DATA_W-1:0]       rdata,
    output mem_stage_pkg::mem_rsp_t  rsp
);
    import mem_stage_pkg::*;

    logic [7:0]         byte_lane;
    logic [15:0]        half_lane;
    logic [`DATA_W-1:0] rt;
    logic [`DATA_W-1:0] load_data;
    logic               store_class;

    assign byte_lane   = rdata[8*m2.addr_low +: 8];
    assign half_lane   = m2.addr_low[1] ? rdata[31:16] : rdata[15:0];
    assign rt          = m2.rt_value;
    assign store_class = is_store_kind(m2.kind);

    always_comb begin
        case (m2.kind)
            KIND_LW, KIND_LL: load_data = rdata;
            KIND_LH:          load_data = {{16{half_lane[15]}}, half_lane};
            KIND_LHU:         load_data = {16'h0000, half_lane};
            KIND_LB:          load_data = {{24{byte_lane[7]}}, byte_lane};
            KIND_LBU:         load_data = {24'h000000, byte_lane};
            KIND_LWL: begin
                // ram bytes fill the top of rt
                case (m2.addr_low)
                    2'b00:   load_data = {rdata[7:0], rt[23:0]};
                    2'b01:   load_data = {rdata[15:0], rt[15:0]};
                    2'b10:   load_data = {rdata[23:0], rt[7:0]};
                    default: load_data = rdata;
                endcase
            end
            KIND_LWR: begin
                // ram bytes fill the bottom of rt
                case (m2.addr_low)
                    2'b00:   load_data = rdata;
                    2'b01:   load_data = {rt[31:24], rdata[31:8]};
                    2'b10:   load_data = {rt[31:16], rdata[31:16]};
                    default: load_data = {rt[31:8], rdata[31:24]};
                endcase
            end
            KIND_SC:  load_data = {31'b0, m2.sc_ok};   // 1 if the word was written
            default:  load_data = '0;                    // plain stores return zero
        endcase
    end

    assign rsp.valid            = m2.valid;
    assign rsp.data             = (m2.valid && !m2.fault) ? load_data : '0;
    assign rsp.addr_error_load  = m2.valid && m2.fault && !store_class;
    assign rsp.addr_error_store = m2.valid && m2.fault && store_class;

    // fault class comes from the kind decoded back in stage M
    always_comb begin
        a_one_error_flag: assert (!(rsp.addr_error_load === 1'b1 &&
                                    rsp.addr_error_store === 1'b1))
            else $error("load and store error flags both set");
    end

endmodule

`default_nettype wire

// ==== mem_access_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_macros.svh"

module mem_access_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_stage_pkg::mem_req_t     req,
    output mem_stage_pkg::ram_wr_t      ram_wr,
    output logic [`RAM_ADDR_W-1:0]      rd_word_addr,
    output mem_stage_pkg::m2_stage_t    m2
);
    import mem_stage_pkg::*;

    access_kind_e       kind;
    logic [1:0]         addr_low;
    logic               misaligned;
    logic               fault;
    logic               link;       // ll/sc reservation
    logic               sc_ok;
    logic               wr_allow;
    logic [3:0]         fmt_be;
    logic [`DATA_W-1:0] fmt_data;

    assign addr_low = req.addr[1:0];

    always_comb begin
        case (req.instr.itype.op)
            `OP_LW:  kind = KIND_LW;
            `OP_LH:  kind = KIND_LH;
            `OP_LHU: kind = KIND_LHU;
            `OP_LB:  kind = KIND_LB;
            `OP_LBU: kind = KIND_LBU;
            `OP_LWL: kind = KIND_LWL;
            `OP_LWR: kind = KIND_LWR;
            `OP_LL:  kind = KIND_LL;
            `OP_SW:  kind = KIND_SW;
            `OP_SH:  kind = KIND_SH;
            `OP_SB:  kind = KIND_SB;
            `OP_SWL: kind = KIND_SWL;
            `OP_SWR: kind = KIND_SWR;
            `OP_SC:  kind = KIND_SC;
            default: kind = KIND_NONE;  // not a memory op
        endcase
    end

    // word kinds need 00, halfword kinds need bit 0 clear
    always_comb begin
        case (kind)
            KIND_LW, KIND_LL, KIND_SW, KIND_SC: misaligned = |addr_low;
            KIND_LH, KIND_LHU, KIND_SH:         misaligned = addr_low[0];
            default:                            misaligned = 1'b0;
        endcase
    end

    assign fault    = req.valid && misaligned;
    assign sc_ok    = (kind == KIND_SC) && link;
    assign wr_allow = req.valid && !fault && ((kind != KIND_SC) || link);

    store_formatter i_store_formatter (
        .kind     (kind),
        .addr_low (addr_low),
        .rt_value (req.rt_value),
        .be       (fmt_be),
        .data     (fmt_data)
    );

    assign ram_wr.be        = wr_allow ? fmt_be : 4'b0000;
    assign ram_wr.word_addr = req.addr[`RAM_ADDR_W+1:2];
    assign ram_wr.data      = fmt_data;
    assign rd_word_addr     = req.addr[`RAM_ADDR_W+1:2];  // upper address bits ignored

    // sc clears the link whether it succeeds or not
    always_ff @(posedge clk) begin
        if (rst) begin
            link <= 1'b0;
        end else if (req.valid && !fault) begin
            if (kind == KIND_LL) begin
                link <= 1'b1;
            end else if (kind == KIND_SC) begin
                link <= 1'b0;
            end
        end
    end

    // M to M2 register
    always_ff @(posedge clk) begin
        m2.kind     <= kind;
        m2.addr_low <= addr_low;
        m2.rt_value <= req.rt_value;
        m2.sc_ok    <= sc_ok;
        m2.fault    <= fault;
        if (rst) begin
            m2.valid <= 1'b0;
        end else begin
            m2.valid <= req.valid;
        end
    end

    // misaligned word or halfword opcode blocks the write and leaves the link bit as it was
    a_fault_no_side_effect: assert property (@(posedge clk) disable iff (rst)
        req.valid &&
        ((req.instr.itype.op inside {`OP_LW, `OP_LL, `OP_SW, `OP_SC} &&
          req.addr[1:0] != 2'b00) ||
         (req.instr.itype.op inside {`OP_LH, `OP_LHU, `OP_SH} && req.addr[0]))
        |-> (ram_wr.be == 4'b0000) ##1 $stable(link));

endmodule

`default_nettype wire

// ==== store_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_macros.svh"

module store_formatter (
    input  mem_stage_pkg::access_kind_e kind,
    input  logic [1:0]                  addr_low,
    input  logic [`DATA_W-1:0]          rt_value,
    output logic [3:0]                  be,
    output logic [`DATA_W-1:0]          data
);
    import mem_stage_pkg::*;

    always_comb begin
        be   = 4'b0000;
        data = rt_value;
        case (kind)
            KIND_SW, KIND_SC: begin
                be = 4'b1111;
            end
            KIND_SH: begin
                be   = addr_low[1] ? 4'b1100 : 4'b0011;
                data = {2{rt_value[15:0]}};         // both halves carry the data
            end
            KIND_SB: begin
                be   = 4'b0001 << addr_low;
                data = {4{rt_value[7:0]}};
            end
            KIND_SWL: begin
                // high bytes of rt down to the addressed byte
                case (addr_low)
                    2'b00: begin
                        be   = 4'b0001;
                        data = {4{rt_value[31:24]}};
                    end
                    2'b01: begin
                        be   = 4'b0011;
                        data = {2{rt_value[31:16]}};
                    end
                    2'b10: begin
                        be   = 4'b0111;
                        data = {8'h00, rt_value[31:8]};
                    end
                    default: begin
                        be   = 4'b1111;
                        data = rt_value;
                    end
                endcase
            end
            KIND_SWR: begin
                // low bytes of rt from the addressed byte up
                case (addr_low)
                    2'b00: begin
                        be   = 4'b1111;
                        data = rt_value;
                    end
                    2'b01: begin
                        be   = 4'b1110;
                        data = {rt_value[23:0], 8'h00};
                    end
                    2'b10: begin
                        be   = 4'b1100;
                        data = {2{rt_value[15:0]}};
                    end
                    default: begin
                        be   = 4'b1000;
                        data = {4{rt_value[7:0]}};
                    end
                endcase
            end
            default: begin
                be = 4'b0000;   // loads and non-memory ops
            end
        endcase

        if (is_store_kind(kind)) begin
            a_store_has_lanes: assert (be != 4'b0000)
                else $error("store kind %s produced no byte enables", kind.name());
        end
    end

endmodule

`default_nettype wire

// ==== mem_stage_pkg.sv ====
`default_nettype none

`include "mem_stage_macros.svh"

package mem_stage_pkg;

    // i-type field view of the instruction word
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } itype_t;

    typedef union packed {
        logic [31:0] raw;
        itype_t      itype;
    } mem_instr_u;

    typedef enum logic [3:0] {
        KIND_NONE, KIND_LW, KIND_LH, KIND_LHU, KIND_LB, KIND_LBU, KIND_LWL, KIND_LWR,
        KIND_LL, KIND_SW, KIND_SH, KIND_SB, KIND_SWL, KIND_SWR, KIND_SC
    } access_kind_e;

    typedef struct packed {
        logic              valid;
        mem_instr_u        instr;
        logic [31:0]       addr;
        logic [`DATA_W-1:0] rt_value;
    } mem_req_t;

    typedef struct packed {
        logic [3:0]            be;
        logic [`RAM_ADDR_W-1:0] word_addr;
        logic [`DATA_W-1:0]    data;
    } ram_wr_t;

    typedef struct packed {
        logic               valid;
        access_kind_e       kind;
        logic [1:0]         addr_low;
        logic [`DATA_W-1:0] rt_value;
        logic               sc_ok;
        logic               fault;
    } m2_stage_t;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] data;
        logic               addr_error_load;
        logic               addr_error_store;
    } mem_rsp_t;

    // store class decides which error flag a fault raises
    function automatic logic is_store_kind(access_kind_e kind);
        return kind inside {KIND_SW, KIND_SH, KIND_SB, KIND_SWL, KIND_SWR, KIND_SC};
    endfunction

endpackage

`default_nettype wire

// ==== mem_stage_macros.svh ====
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// datapath and RAM geometry
`define DATA_W     32
`define RAM_ADDR_W 8    // word address bits, 256 words

// load opcodes
`define OP_LB  6'b100000
`define OP_LH  6'b100001
`define OP_LWL 6'b100010
`define OP_LW  6'b100011
`define OP_LBU 6'b100100
`define OP_LHU 6'b100101
`define OP_LWR 6'b100110
`define OP_LL  6'b110000

// store opcodes
`define OP_SB  6'b101000
`define OP_SH  6'b101001
`define OP_SWL 6'b101010
`define OP_SW  6'b101011
`define OP_SWR 6'b101110
`define OP_SC  6'b111000

`endif
